// ==== cpuPkg.sv ====
package cpuPkg;

        localparam int dataW    = 32;
        localparam int regAddrW = 5;
        localparam int shamtW   = 5;
        localparam int opW      = 6;
        localparam int regN     = 32;

        // MIPS major opcodes of the supported subset
        typedef enum logic [opW-1:0] {
                rType = 6'h00,
                addi  = 6'h08,
                andi  = 6'h0c,
                ori   = 6'h0d,
                lui   = 6'h0f
        } opcodeE;

        typedef enum logic [opW-1:0] {
                sll   = 6'h00,
                srl   = 6'h02,
                mult  = 6'h18,   // only the low word of the product is kept
                add   = 6'h20,
                sub   = 6'h22,
                andOp = 6'h24,
                orOp  = 6'h25,
                slt   = 6'h2a
        } funcE;

        typedef enum logic [3:0] {
                opAdd, opSub, opAnd, opOr, opSlt, opSll, opSrl, opMul, opLui
        } aluOpE;

        typedef struct packed {
                logic  regDst;    // destination from rd instead of rt
                logic  aluSrc;    // operand b is the immediate
                logic  regWrite;
                logic  shiftSel;  // immediate goes to the upper half
                aluOpE aluOp;
        } ctrlT;

        typedef struct packed {
                logic                valid;
                ctrlT                ctrl;
                logic [dataW-1:0]    rsData;
                logic [dataW-1:0]    rtData;
                logic [dataW-1:0]    immData;
                logic [shamtW-1:0]   shamt;
                logic [regAddrW-1:0] rAddr;
        } decExT;

        typedef struct packed {
                logic                valid;
                logic [regAddrW-1:0] addr;
                logic [dataW-1:0]    data;
        } wbT;

endpackage

// ==== instrFetch.sv ====
`timescale 1ns/1ps

module instrFetch (
        input  logic                     Clock,
        input  logic                     arstN,
        input  logic                     instrReq,
        input  logic [cpuPkg::dataW-1:0] instrData,
        output logic                     instrAck,
        output logic                     fetchValid,
        output logic [cpuPkg::dataW-1:0] fetchWord,
        input  logic                     take
);

        typedef enum logic [1:0] {idle, full, waitDrop} fetchStateE;

        fetchStateE state;

        assign fetchValid = (state == full);

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        state    <= idle;
                        instrAck <= 1'b0;
                end else begin
                        case (state)
                                idle: begin
                                        if (instrReq) begin      // buffer is empty so accept at once
                                                instrAck <= 1'b1;
                                                state    <= full;
                                        end
                                end
                                full: begin
                                        if (!instrReq)
                                                instrAck <= 1'b0;
                                        if (take)                // a held ack still waits for the drop
                                                state <= (instrAck && instrReq) ? waitDrop : idle;
                                end
                                waitDrop: begin
                                        if (!instrReq) begin
                                                instrAck <= 1'b0;
                                                state    <= idle;
                                        end
                                end
                                default: state <= idle;
                        endcase
                end
        end

        // the word register only loads on an accepted request
        always_ff @(posedge Clock) begin
                if (state == idle && instrReq)
                        fetchWord <= instrData;
        end

        ackNeedsReq: assert property (@(posedge Clock) disable iff (!arstN)
                $rose(instrAck) |-> $past(instrReq))
                else $error("instrAck rose without a pending request");

endmodule

// ==== controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
        input  cpuPkg::opcodeE opcode,
        input  cpuPkg::funcE   funct,
        output cpuPkg::ctrlT   ctrl
);

        always_comb begin
                ctrl.regDst   = 1'b0;
                ctrl.aluSrc   = 1'b0;
                ctrl.regWrite = 1'b0;           // unknown encodings fall through as no-ops
                ctrl.shiftSel = 1'b0;
                ctrl.aluOp    = cpuPkg::opAdd;

                case (opcode)
                        cpuPkg::rType: begin
                                ctrl.regDst   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                case (funct)
                                        cpuPkg::add:   ctrl.aluOp = cpuPkg::opAdd;
                                        cpuPkg::sub:   ctrl.aluOp = cpuPkg::opSub;
                                        cpuPkg::andOp: ctrl.aluOp = cpuPkg::opAnd;
                                        cpuPkg::orOp:  ctrl.aluOp = cpuPkg::opOr;
                                        cpuPkg::slt:   ctrl.aluOp = cpuPkg::opSlt;
                                        cpuPkg::sll:   ctrl.aluOp = cpuPkg::opSll;
                                        cpuPkg::srl:   ctrl.aluOp = cpuPkg::opSrl;
                                        cpuPkg::mult:  ctrl.aluOp = cpuPkg::opMul;
                                        default:       ctrl.regWrite = 1'b0;
                                endcase
                        end
                        cpuPkg::addi: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluOp    = cpuPkg::opAdd;
                        end
                        cpuPkg::andi: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluOp    = cpuPkg::opAnd;
                        end
                        cpuPkg::ori: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluOp    = cpuPkg::opOr;
                        end
                        cpuPkg::lui: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.shiftSel = 1'b1;   // rides the upper-half immediate path
                                ctrl.aluOp    = cpuPkg::opLui;
                        end
                        default: ;
                endcase
        end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
        input  logic                        Clock,
        input  logic                        arstN,
        input  cpuPkg::wbT                  wb,
        input  logic [cpuPkg::regAddrW-1:0] rsAddr,
        input  logic [cpuPkg::regAddrW-1:0] rtAddr,
        output logic [cpuPkg::dataW-1:0]    rsData,
        output logic [cpuPkg::dataW-1:0]    rtData
);

        logic [cpuPkg::dataW-1:0] regs [cpuPkg::regN];

        logic wrEn;

        assign wrEn = wb.valid && (wb.addr != '0);   // register zero is never written

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        for (int i = 0; i < cpuPkg::regN; i++)
                                regs[i] <= '0;
                end else if (wrEn) begin
                        regs[wb.addr] <= wb.data;
                end
        end

        // write-first so decode sees a result in the cycle it is written
        always_comb begin
                if (wrEn && wb.addr == rsAddr)
                        rsData = wb.data;
                else
                        rsData = regs[rsAddr];

                if (wrEn && wb.addr == rtAddr)
                        rtData = wb.data;
                else
                        rtData = regs[rtAddr];
        end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
        input  logic                        Clock,
        input  logic                        arstN,
        input  logic                        fetchValid,
        input  logic [cpuPkg::dataW-1:0]    fetchWord,
        output logic                        take,
        output logic [cpuPkg::regAddrW-1:0] rsAddr,
        output logic [cpuPkg::regAddrW-1:0] rtAddr,
        input  logic [cpuPkg::dataW-1:0]    rsData,
        input  logic [cpuPkg::dataW-1:0]    rtData,
        input  cpuPkg::decExT               exBusy,
        output cpuPkg::decExT               decEx
);

        cpuPkg::opcodeE              opcode;
        cpuPkg::funcE                funct;
        cpuPkg::ctrlT                ctrl;
        cpuPkg::decExT               decNext;
        logic [cpuPkg::regAddrW-1:0] rdAddr;
        logic [15:0]                 imm;
        logic                        rsUsed;
        logic                        rtUsed;
        logic                        hazard;

        assign opcode = cpuPkg::opcodeE'(fetchWord[31:26]);
        assign funct  = cpuPkg::funcE'(fetchWord[5:0]);
        assign rsAddr = fetchWord[25:21];
        assign rtAddr = fetchWord[20:16];
        assign rdAddr = fetchWord[15:11];
        assign imm    = fetchWord[15:0];

        controlDecoder dec0 (
                .opcode(opcode),
                .funct (funct),
                .ctrl  (ctrl)
        );

        // shifts and lui ignore rs, immediates ignore rt
        assign rsUsed = !ctrl.shiftSel && ctrl.aluOp != cpuPkg::opSll
                        && ctrl.aluOp != cpuPkg::opSrl;
        assign rtUsed = !ctrl.aluSrc;

        // the result in execute reaches the register file one cycle too late
        assign hazard = fetchValid && exBusy.valid && exBusy.ctrl.regWrite
                        && exBusy.rAddr != '0
                        && ((rsUsed && rsAddr == exBusy.rAddr)
                            || (rtUsed && rtAddr == exBusy.rAddr));

        assign take = fetchValid && !hazard;

        always_comb begin
                decNext.valid   = take;   // a stall leaves a bubble behind
                decNext.ctrl    = ctrl;
                decNext.rsData  = rsData;
                decNext.rtData  = rtData;
                decNext.immData = ctrl.shiftSel ? {imm, 16'd0} : {{16{imm[15]}}, imm};
                decNext.shamt   = fetchWord[10:6];
                decNext.rAddr   = ctrl.regDst ? rdAddr : rtAddr;
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN)
                        decEx <= '0;
                else
                        decEx <= decNext;
        end

        // the bubble clears execute, so the held word goes on the next cycle
        stallOneCycle: assert property (@(posedge Clock) disable iff (!arstN)
                hazard |=> take)
                else $error("decode stalled for more than one cycle");

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
        input  logic          Clock,
        input  logic          arstN,
        input  cpuPkg::decExT decEx,
        output cpuPkg::wbT    wb
);

        logic [cpuPkg::dataW-1:0] opB;
        logic [cpuPkg::dataW-1:0] result;
        logic                     lessThan;

        assign opB      = decEx.ctrl.aluSrc ? decEx.immData : decEx.rtData;
        assign lessThan = $signed(decEx.rsData) < $signed(opB);

        always_comb begin
                case (decEx.ctrl.aluOp)
                        cpuPkg::opAdd: result = decEx.rsData + opB;
                        cpuPkg::opSub: result = decEx.rsData - opB;
                        cpuPkg::opAnd: result = decEx.rsData & opB;
                        cpuPkg::opOr:  result = decEx.rsData | opB;
                        cpuPkg::opSlt: result = {{(cpuPkg::dataW-1){1'b0}}, lessThan};
                        cpuPkg::opSll: result = decEx.rtData << decEx.shamt;
                        cpuPkg::opSrl: result = decEx.rtData >> decEx.shamt;
                        cpuPkg::opMul: result = decEx.rsData * opB;   // low word only
                        cpuPkg::opLui: result = decEx.immData;       // already shifted up in decode
                        default:       result = '0;
                endcase
        end

        always_ff @(posedge Clock or negedge arstN) begin
                if (!arstN) begin
                        wb <= '0;
                end else begin
                        wb.valid <= decEx.valid && decEx.ctrl.regWrite;
                        wb.addr  <= decEx.rAddr;
                        wb.data  <= result;
                end
        end

        wbFollowsIssue: assert property (@(posedge Clock) disable iff (!arstN)
                wb.valid |-> $past(decEx.valid))
                else $error("writeback without an instruction in execute");

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
        input  logic                     Clock,
        input  logic                     arstN,
        input  logic                     instrReq,
        input  logic [cpuPkg::dataW-1:0] instrData,
        output logic                     instrAck,
        output cpuPkg::wbT               wb
);

        logic                        fetchValid;
        logic [cpuPkg::dataW-1:0]    fetchWord;
        logic                        take;
        logic [cpuPkg::regAddrW-1:0] rsAddr;
        logic [cpuPkg::regAddrW-1:0] rtAddr;
        logic [cpuPkg::dataW-1:0]    rsData;
        logic [cpuPkg::dataW-1:0]    rtData;
        cpuPkg::decExT               decEx;

        instrFetch fetch0 (
                .Clock     (Clock),
                .arstN     (arstN),
                .instrReq  (instrReq),
                .instrData (instrData),
                .instrAck  (instrAck),
                .fetchValid(fetchValid),
                .fetchWord (fetchWord),
                .take      (take)
        );

        decodeStage dec0 (
                .Clock     (Clock),
                .arstN     (arstN),
                .fetchValid(fetchValid),
                .fetchWord (fetchWord),
                .take      (take),
                .rsAddr    (rsAddr),
                .rtAddr    (rtAddr),
                .rsData    (rsData),
                .rtData    (rtData),
                .exBusy    (decEx),    // execute's current instruction for the hazard check
                .decEx     (decEx)
        );

        regFile reg0 (
                .Clock (Clock),
                .arstN (arstN),
                .wb    (wb),
                .rsAddr(rsAddr),
                .rtAddr(rtAddr),
                .rsData(rsData),
                .rtData(rtData)
        );

        executeStage ex0 (
                .Clock(Clock),
                .arstN(arstN),
                .decEx(decEx),
                .wb   (wb)
        );

endmodule

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;

        logic                     Clock = 1'b0;
        logic                     arstN;
        logic                     instrReq;
        logic [cpuPkg::dataW-1:0] instrData;
        logic                     instrAck;
        cpuPkg::wbT               wb;

        cpuPkg::wbT               expQ [$];
        cpuPkg::wbT               expHead;
        logic [cpuPkg::dataW-1:0] model [32];
        string                    curTest;
        integer                   seed = 65809;
        int                       errCount = 0;
        int                       checkCount = 0;
        int                       sentCount = 0;
        int                       writeCount = 0;
        int                       wbCount = 0;
        int                       ackRises = 0;
        int                       testCount = 0;
        int                       errAtStart = 0;
        int                       testInstr = 0;
        int                       cycles = 0;
        int                       holdMax = 0;
        logic                     ackPrev = 1'b0;

        cpuTop dut0 (
                .Clock    (Clock),
                .arstN    (arstN),
                .instrReq (instrReq),
                .instrData(instrData),
                .instrAck (instrAck),
                .wb       (wb)
        );

        always #5 Clock = ~Clock;

        function automatic int randIdx(input int span);
                int r;
                r = $random(seed);
                return (r & 32'h7fff_ffff) % span;
        endfunction

        function automatic logic [4:0] randReg(input int lo, input int span);
                int r;
                r = lo + randIdx(span);
                return r[4:0];
        endfunction

        function automatic logic [15:0] rand16();
                logic [31:0] r;
                r = $random(seed);
                return r[15:0];
        endfunction

        function automatic cpuPkg::funcE aluFunc(input int n);
                case (n % 5)
                        0:       return cpuPkg::add;
                        1:       return cpuPkg::sub;
                        2:       return cpuPkg::andOp;
                        3:       return cpuPkg::orOp;
                        default: return cpuPkg::slt;
                endcase
        endfunction

        function automatic cpuPkg::opcodeE immOp(input int n);
                case (n % 4)
                        0:       return cpuPkg::addi;
                        1:       return cpuPkg::andi;
                        2:       return cpuPkg::ori;
                        default: return cpuPkg::lui;
                endcase
        endfunction

        function automatic logic [31:0] rWord(input cpuPkg::funcE f, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd,
                                              input logic [4:0] sh);
                return {cpuPkg::rType, rs, rt, rd, sh, f};
        endfunction

        function automatic logic [31:0] iWord(input cpuPkg::opcodeE op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        // architectural result of one instruction against the model registers
        function automatic cpuPkg::wbT expectWb(input logic [31:0] w);
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] sext;
                cpuPkg::wbT  e;
                a       = model[w[25:21]];
                b       = model[w[20:16]];
                sext    = {{16{w[15]}}, w[15:0]};
                e.valid = 1'b1;
                e.addr  = w[20:16];
                e.data  = '0;
                case (w[31:26])
                        cpuPkg::rType: begin
                                e.addr = w[15:11];
                                case (w[5:0])
                                        cpuPkg::add:   e.data = a + b;
                                        cpuPkg::sub:   e.data = a - b;
                                        cpuPkg::andOp: e.data = a & b;
                                        cpuPkg::orOp:  e.data = a | b;
                                        cpuPkg::slt:   e.data = {31'd0, $signed(a) < $signed(b)};
                                        cpuPkg::sll:   e.data = b << w[10:6];
                                        cpuPkg::srl:   e.data = b >> w[10:6];
                                        cpuPkg::mult:  e.data = a * b;   // low word of the product
                                        default:       e.valid = 1'b0;
                                endcase
                        end
                        cpuPkg::addi: e.data = a + sext;
                        cpuPkg::andi: e.data = a & sext;
                        cpuPkg::ori:  e.data = a | sext;
                        cpuPkg::lui:  e.data = {w[15:0], 16'h0000};
                        default:      e.valid = 1'b0;
                endcase
                return e;
        endfunction

        // four-phase transfer of one word, entered and left 1 ns after a rising edge
        task automatic sendInstr(input logic [31:0] w);
                cpuPkg::wbT e;
                int         hold;
                e = expectWb(w);
                if (e.valid) begin
                        if (e.addr != 5'd0)
                                model[e.addr] = e.data;   // register zero keeps reading zero
                        expQ.push_back(e);
                        writeCount++;
                end
                sentCount++;
                testInstr++;
                instrData = w;
                instrReq  = 1'b1;
                do begin
                        @(posedge Clock);
                        #1;
                end while (!instrAck);
                hold = (holdMax > 0) ? randIdx(holdMax) : 0;
                repeat (hold) begin   // a request kept up past the ack must hold the ack too
                        @(posedge Clock);
                        #1;
                end
                instrReq = 1'b0;
                do begin
                        @(posedge Clock);
                        #1;
                end while (instrAck);
        endtask

        task automatic startTest(input string name);
                curTest    = name;
                testInstr  = 0;
                errAtStart = errCount;
        endtask

        task automatic finishTest();
                while (expQ.size() != 0) begin
                        @(posedge Clock);
                        #1;
                end
                repeat (4) @(posedge Clock);   // room for a stray writeback to show up
                #1;
                testCount++;
                $display("test %s: %0d instructions, %0d errors", curTest, testInstr,
                         errCount - errAtStart);
        endtask

        always @(negedge Clock) begin
                if (arstN && wb.valid) begin
                        if (expQ.size() == 0) begin
                                errCount++;
                                $display("writeback to r%0d arrived with nothing outstanding",
                                         wb.addr);
                        end else begin
                                expHead = expQ.pop_front();
                                wbCount++;
                                checkCount++;
                                wbMatch: assert (wb == expHead) else begin
                                        errCount++;
                                        $display("ERR %s expected r%0d=%h actual r%0d=%h",
                                                 curTest, expHead.addr, expHead.data,
                                                 wb.addr, wb.data);
                                end
                        end
                end
        end

        always @(negedge Clock) begin
                if (instrAck && !ackPrev)
                        ackRises++;
                ackPrev = instrAck;
        end

        ackHeld: assert property (@(posedge Clock) disable iff (!arstN)
                (instrAck && instrReq) |=> instrAck)
                else begin
                        errCount++;
                        $display("instrAck fell while instrReq was still high");
                end

        // the limit grows with every instruction sent
        initial begin
                while (cycles <= sentCount * 200 + 1000) begin
                        @(posedge Clock);
                        cycles++;
                end
                $display("timeout: the run made no progress after %0d cycles", cycles);
                $display("Done: errors found");
                $finish;
        end

        initial begin
                logic [4:0] cur;
                logic [4:0] nxt;
                instrReq  = 1'b0;
                instrData = '0;
                arstN     = 1'b0;
                foreach (model[i])
                        model[i] = '0;
                repeat (10) @(posedge Clock);
                #1 arstN = 1'b1;

                startTest("resetAlu");
                repeat (8) begin
                        @(posedge Clock);
                        #1;
                        quietAfterReset: assert (!instrAck && !wb.valid) else begin
                                errCount++;
                                $display("instrAck or wb.valid went high before any request");
                        end
                end
                for (int i = 1; i <= 8; i++) begin
                        sendInstr(iWord(cpuPkg::lui, 5'd0, 5'(i), rand16()));
                        sendInstr(iWord(cpuPkg::ori, 5'(i), 5'(i), rand16()));
                end
                for (int k = 0; k < 15; k++)
                        sendInstr(rWord(aluFunc(k), randReg(1, 8), randReg(1, 8),
                                        randReg(9, 7), 5'd0));
                finishTest();

                startTest("immediate");
                for (int k = 0; k < 4; k++) begin
                        sendInstr(iWord(cpuPkg::addi, randReg(1, 8), randReg(9, 7), rand16()));
                        sendInstr(iWord(cpuPkg::addi, randReg(1, 8), randReg(9, 7),
                                        rand16() | 16'h8000));   // negative immediate
                        sendInstr(iWord(cpuPkg::andi, randReg(1, 8), randReg(9, 7),
                                        rand16() | 16'h8000));
                        sendInstr(iWord(cpuPkg::ori, randReg(1, 8), randReg(9, 7), rand16()));
                        sendInstr(iWord(cpuPkg::lui, randReg(0, 32), randReg(9, 7), rand16()));
                end
                finishTest();

                startTest("shiftMul");
                for (int k = 0; k < 6; k++) begin
                        sendInstr(rWord(cpuPkg::sll, 5'd0, randReg(1, 8), randReg(9, 7),
                                        randReg(0, 32)));
                        sendInstr(rWord(cpuPkg::srl, 5'd0, randReg(1, 8), randReg(9, 7),
                                        randReg(0, 32)));
                        sendInstr(rWord(cpuPkg::mult, randReg(1, 8), randReg(1, 8),
                                        randReg(9, 7), 5'd0));
                end
                finishTest();

                startTest("chain");
                cur = 5'd16;
                sendInstr(iWord(cpuPkg::addi, 5'd1, cur, rand16()));
                for (int k = 0; k < 8; k++) begin
                        nxt = cur + 5'd1;   // each step reads the previous destination
                        sendInstr(rWord(aluFunc(k), cur, randReg(1, 8), nxt, 5'd0));
                        cur = nxt;
                end
                sendInstr(iWord(cpuPkg::ori, cur, cur, rand16()));
                sendInstr(rWord(cpuPkg::sll, 5'd0, cur, 5'd25, 5'd3));
                finishTest();

                startTest("zeroReg");
                sendInstr(iWord(cpuPkg::addi, 5'd3, 5'd0, rand16()));
                sendInstr(rWord(cpuPkg::add, 5'd4, 5'd5, 5'd0, 5'd0));
                sendInstr(rWord(cpuPkg::add, 5'd0, 5'd6, 5'd22, 5'd0));
                sendInstr(rWord(cpuPkg::add, 5'd7, 5'd0, 5'd23, 5'd0));
                finishTest();

                startTest("randomMix");
                holdMax = 3;
                for (int k = 0; k < 40; k++) begin
                        case (randIdx(4))
                                0: sendInstr(rWord(aluFunc(randIdx(5)), randReg(0, 32),
                                                   randReg(0, 32), randReg(0, 32), 5'd0));
                                1: sendInstr(rWord(randIdx(2) == 0 ? cpuPkg::sll : cpuPkg::srl,
                                                   5'd0, randReg(0, 32), randReg(0, 32),
                                                   randReg(0, 32)));
                                2: sendInstr(rWord(cpuPkg::mult, randReg(0, 32), randReg(0, 32),
                                                   randReg(0, 32), 5'd0));
                                default: sendInstr(iWord(immOp(randIdx(4)), randReg(0, 32),
                                                         randReg(0, 32), rand16()));
                        endcase
                end
                finishTest();

                ackCount: assert (ackRises == sentCount) else begin
                        errCount++;
                        $display("ERR ackCount expected %0d actual %0d", sentCount, ackRises);
                end
                wbTotal: assert (wbCount == writeCount) else begin
                        errCount++;
                        $display("ERR wbCount expected %0d actual %0d", writeCount, wbCount);
                end
                $display("tests %0d, instructions %0d, writebacks %0d, checks %0d, errors %0d",
                         testCount, sentCount, wbCount, checkCount, errCount);
                if (errCount == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

// ==== flist.f ====
cpuPkg.sv
instrFetch.sv
controlDecoder.sv
regFile.sv
decodeStage.sv
executeStage.sv
cpuTop.sv
tbCpu.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCpu -f flist.f -o simCpu

if ./obj_dir/simCpu | tee /dev/stderr | grep -x "Done: no errors" > /dev/null; then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi
